// File: arm_dec_params.svh
`ifndef ARM_DEC_PARAMS_SVH
`define ARM_DEC_PARAMS_SVH

// instruction and address width
`define ARM_WORD_W 32

// register index width
`define ARM_REG_W 4

// condition field, also NZCV width
`define ARM_COND_W 4

// sequential fetch step in bytes
`define ARM_PC_STEP 4

// signed word offset of B / BL
`define ARM_BOFS_W 24

// r14, written by BL
`define ARM_LINK_REG 14

`endif

// File: arm_dec_pkg.sv
`default_nettype none

`include "arm_dec_params.svh"

package arm_dec_pkg;

    // instruction class, bits 27..25
    // 100, 110 and 111 are left undefined
    typedef enum logic [2:0] {
        CLS_DP_SHIFT = 3'b000,
        CLS_DP_IMM   = 3'b001,
        CLS_LS_IMM   = 3'b010,
        CLS_LS_REG   = 3'b011,
        CLS_BRANCH   = 3'b101
    } insn_class_t;

    // condition field, bits 31..28
    typedef enum logic [`ARM_COND_W-1:0] {
        COND_EQ = 4'h0,
        COND_NE = 4'h1,
        COND_CS = 4'h2,
        COND_CC = 4'h3,
        COND_MI = 4'h4,
        COND_PL = 4'h5,
        COND_VS = 4'h6,
        COND_VC = 4'h7,
        COND_HI = 4'h8,
        COND_LS = 4'h9,
        COND_GE = 4'ha,
        COND_LT = 4'hb,
        COND_GT = 4'hc,
        COND_LE = 4'hd,
        COND_AL = 4'he,
        COND_NV = 4'hf
    } cond_t;

    // alu opcodes forced by the decoder
    localparam logic [3:0] ALU_ADD = 4'b0100;
    localparam logic [3:0] ALU_SUB = 4'b0010;

    // control word, all zero is a no-op
    typedef struct packed {
        logic       shift_imm;
        logic [3:0] alu_op;
        logic       load;
        logic       rf_write;
        logic       mem_write;
        logic       branch;
        logic       link;
    } ctrl_t;

    // record held by the output slice
    typedef struct packed {
        logic [`ARM_WORD_W-1:0] pc;
        logic [`ARM_REG_W-1:0]  rd;
        ctrl_t                  ctrl;
        logic                   cond_pass;
    } dec_t;

endpackage

`default_nettype wire

// File: stage_reg.sv
`default_nettype none
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // occupancy of the single entry
    logic     full;
    // held item
    payload_t data_q;
    logic     push;
    logic     pop;

    // leaving item makes room in the same cycle
    assign pop      = full && out_ready;
    assign in_ready = !full || pop;
    assign push     = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            full <= 1'b0;
        end
        else if (push)
        begin
            full <= 1'b1;
        end
        else if (pop)
        begin
            full <= 1'b0;
        end
    end

    // payload only moves on a push
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            data_q <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data  = data_q;

endmodule

`default_nettype wire

// File: insn_decoder.sv
`default_nettype none
`timescale 1ns/1ns

`include "arm_dec_params.svh"

module insn_decoder (
    input  logic [`ARM_WORD_W-1:0] instr,
    output arm_dec_pkg::ctrl_t     ctrl,
    output logic [`ARM_REG_W-1:0]  rd
);

    import arm_dec_pkg::*;

    insn_class_t cls;
    // L bit of load/store
    logic        ls_load;
    // U bit, offset added when set
    logic        ls_up;
    // L bit of branch, link when set
    logic        br_link;

    assign cls     = insn_class_t'(instr[27:25]);
    assign ls_load = instr[20];
    assign ls_up   = instr[23];
    assign br_link = instr[24];

    always_comb
    begin
        // defaults give the no-op record
        ctrl = '0;
        rd   = instr[15:12];

        case (cls)
            CLS_DP_SHIFT,
            CLS_DP_IMM:
            begin
                // opcode passed straight to the alu
                ctrl.rf_write  = 1'b1;
                ctrl.alu_op    = instr[24:21];
                ctrl.shift_imm = (cls == CLS_DP_IMM);
            end

            CLS_LS_IMM,
            CLS_LS_REG:
            begin
                // ldr writes rd, str writes memory
                ctrl.load      = ls_load;
                ctrl.rf_write  = ls_load;
                ctrl.mem_write = !ls_load;
                // address = base +/- offset
                ctrl.alu_op    = ls_up ? ALU_ADD : ALU_SUB;
            end

            CLS_BRANCH:
            begin
                ctrl.branch = 1'b1;
                if (br_link)
                begin
                    // bl saves the return address in r14
                    ctrl.link     = 1'b1;
                    ctrl.rf_write = 1'b1;
                    ctrl.alu_op   = ALU_ADD;
                    rd            = `ARM_REG_W'(`ARM_LINK_REG);
                end
            end

            default:
            begin
                // undefined class, nothing happens
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: cond_unit.sv
`default_nettype none
`timescale 1ns/1ns

`include "arm_dec_params.svh"

module cond_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flags_we,
    input  logic [`ARM_COND_W-1:0] flags,
    input  arm_dec_pkg::cond_t     cond,
    output logic                   pass
);

    import arm_dec_pkg::*;

    // status register, N Z C V from msb down
    logic [`ARM_COND_W-1:0] nzcv;
    logic                   n;
    logic                   z;
    logic                   c;
    logic                   v;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            nzcv <= '0;
        end
        else if (flags_we)
        begin
            nzcv <= flags;
        end
    end

    assign n = nzcv[3];
    assign z = nzcv[2];
    assign c = nzcv[1];
    assign v = nzcv[0];

    always_comb
    begin
        case (cond)
            COND_EQ: pass = z;
            COND_NE: pass = !z;
            COND_CS: pass = c;
            COND_CC: pass = !c;
            COND_MI: pass = n;
            COND_PL: pass = !n;
            COND_VS: pass = v;
            COND_VC: pass = !v;
            // unsigned compares
            COND_HI: pass = c && !z;
            COND_LS: pass = !c || z;
            // signed compares
            COND_GE: pass = (n == v);
            COND_LT: pass = (n != v);
            COND_GT: pass = !z && (n == v);
            COND_LE: pass = z || (n != v);
            COND_AL: pass = 1'b1;
            COND_NV: pass = 1'b0;
            default: pass = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: pc_unit.sv
`default_nettype none
`timescale 1ns/1ns

`include "arm_dec_params.svh"

module pc_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   advance,
    input  logic                   taken,
    input  logic [`ARM_BOFS_W-1:0] offset,
    output logic [`ARM_WORD_W-1:0] pc
);

    logic [`ARM_WORD_W-1:0] pc_plus4;
    // word offset as a byte offset
    logic [`ARM_WORD_W-1:0] ofs_x4;
    logic [`ARM_WORD_W-1:0] target;

    assign pc_plus4 = pc + `ARM_WORD_W'(`ARM_PC_STEP);

    // sign extend then scale by four
    assign ofs_x4 = {{(`ARM_WORD_W - `ARM_BOFS_W - 2){offset[`ARM_BOFS_W-1]}}, offset, 2'b00};

    // relative to the next pc
    assign target = pc_plus4 + ofs_x4;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc <= '0;
        end
        else if (advance)
        begin
            // one step per retired instruction
            pc <= taken ? target : pc_plus4;
        end
    end

endmodule

`default_nettype wire

// File: arm_fetch_decode.sv
`default_nettype none
`timescale 1ns/1ns

`include "arm_dec_params.svh"

module arm_fetch_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    output logic                   instr_ready,
    input  logic [`ARM_WORD_W-1:0] instr,
    input  logic                   flags_we,
    input  logic [`ARM_COND_W-1:0] flags,
    output logic                   dec_valid,
    input  logic                   dec_ready,
    output logic [`ARM_WORD_W-1:0] dec_pc,
    output logic [`ARM_REG_W-1:0]  dec_rd,
    output arm_dec_pkg::ctrl_t     dec_ctrl,
    output logic                   dec_cond_pass
);

    import arm_dec_pkg::*;

    // instruction held in the input slice
    logic                   iq_valid;
    logic [`ARM_WORD_W-1:0] iq_instr;
    // output slice ready, gates retirement
    logic                   oq_ready;
    logic                   retire;

    ctrl_t                  raw_ctrl;
    logic [`ARM_REG_W-1:0]  rd;
    logic                   pass;
    logic [`ARM_WORD_W-1:0] pc;
    dec_t                   mid_rec;
    dec_t                   out_rec;

    stage_reg #(
        .payload_t (logic [`ARM_WORD_W-1:0])
    ) in_slice_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (instr_valid),
        .in_ready  (instr_ready),
        .in_data   (instr),
        .out_valid (iq_valid),
        .out_ready (oq_ready),
        .out_data  (iq_instr)
    );

    insn_decoder insn_decoder_i (
        .instr (iq_instr),
        .ctrl  (raw_ctrl),
        .rd    (rd)
    );

    // condition taken from bits 31..28
    cond_unit cond_unit_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .flags_we (flags_we),
        .flags    (flags),
        .cond     (cond_t'(iq_instr[31:28])),
        .pass     (pass)
    );

    // item moves from input slice to output slice
    assign retire = iq_valid && oq_ready;

    // failed branches fall through to pc + 4
    pc_unit pc_unit_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (retire),
        .taken   (raw_ctrl.branch && pass),
        .offset  (iq_instr[`ARM_BOFS_W-1:0]),
        .pc      (pc)
    );

    // pc before the update travels with the item
    assign mid_rec.pc        = pc;
    assign mid_rec.rd        = rd;
    // failed condition squashes to a no-op
    assign mid_rec.ctrl      = pass ? raw_ctrl : '0;
    assign mid_rec.cond_pass = pass;

    stage_reg #(
        .payload_t (dec_t)
    ) out_slice_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (iq_valid),
        .in_ready  (oq_ready),
        .in_data   (mid_rec),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .out_data  (out_rec)
    );

    assign dec_pc        = out_rec.pc;
    assign dec_rd        = out_rec.rd;
    assign dec_ctrl      = out_rec.ctrl;
    assign dec_cond_pass = out_rec.cond_pass;

endmodule

`default_nettype wire

// File: tb_arm_fetch_decode.sv
`default_nettype none
`timescale 1ns/1ns

`include "arm_dec_params.svh"

module tb_arm_fetch_decode;

    import arm_dec_pkg::*;

    localparam int N_CLASS  = 48;
    localparam int N_TRIALS = 32;
    localparam int N_BRANCH = 12;
    localparam int N_RAND   = 200;
    localparam int N_TOTAL  = N_CLASS + 16 * N_TRIALS + N_BRANCH + N_RAND;
    localparam int TIMEOUT_CYCLES = 4 * N_TOTAL + 200;

    logic                    clk;
    logic                    rst_n;
    logic                    instr_valid;
    logic                    instr_ready;
    logic [`ARM_WORD_W-1:0]  instr;
    logic                    flags_we;
    logic [`ARM_COND_W-1:0]  flags;
    logic                    dec_valid;
    logic                    dec_ready;
    logic [`ARM_WORD_W-1:0]  dec_pc;
    logic [`ARM_REG_W-1:0]   dec_rd;
    ctrl_t                   dec_ctrl;
    logic                    dec_cond_pass;

    integer                  seed;
    int                      value_errors;
    int                      other_errors;
    int                      cycle_count;
    int                      records_seen;
    // dec_ready held high, so latency is fixed
    logic                    fixed_lat;
    logic                    ready_low_seen;
    // reference model: next pc, status flags, records in flight
    logic [`ARM_WORD_W-1:0]  model_pc;
    logic [`ARM_COND_W-1:0]  model_flags;
    dec_t                    exp_q[$];
    int                      acc_cyc_q[$];
    dec_t                    exp_rec;
    int                      acc_cyc;
    // record stalled by dec_ready low at the last edge
    logic                    hold_valid;
    logic [$bits(dec_t)-1:0] hold_rec;

    arm_fetch_decode arm_fetch_decode_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr_ready   (instr_ready),
        .instr         (instr),
        .flags_we      (flags_we),
        .flags         (flags),
        .dec_valid     (dec_valid),
        .dec_ready     (dec_ready),
        .dec_pc        (dec_pc),
        .dec_rd        (dec_rd),
        .dec_ctrl      (dec_ctrl),
        .dec_cond_pass (dec_cond_pass)
    );

    always
    begin
        #20 clk = ~clk;
    end

    // even codes test a flag term, the odd code next to it inverts it
    function automatic logic cond_holds(input logic [3:0] code, input logic [3:0] nzcv);
        logic base;
        begin
            case (code[3:1])
                3'd0: base = nzcv[2];
                3'd1: base = nzcv[1];
                3'd2: base = nzcv[3];
                3'd3: base = nzcv[0];
                3'd4: base = nzcv[1] & ~nzcv[2];
                3'd5: base = (nzcv[3] == nzcv[0]);
                3'd6: base = ~nzcv[2] & (nzcv[3] == nzcv[0]);
                default: base = 1'b1;
            endcase
            cond_holds = code[0] ? ~base : base;
        end
    endfunction

    function automatic ctrl_t expect_ctrl(input logic [31:0] w);
        ctrl_t r;
        begin
            r = '0;
            case (w[27:25])
                3'b000, 3'b001:
                begin
                    r.rf_write  = 1'b1;
                    r.alu_op    = w[24:21];
                    r.shift_imm = w[25];
                end
                3'b010, 3'b011:
                begin
                    r.load      = w[20];
                    r.rf_write  = w[20];
                    r.mem_write = ~w[20];
                    r.alu_op    = w[23] ? ALU_ADD : ALU_SUB;
                end
                3'b101:
                begin
                    r.branch   = 1'b1;
                    r.link     = w[24];
                    r.rf_write = w[24];
                    r.alu_op   = w[24] ? ALU_ADD : 4'b0000;
                end
                default: r = '0;
            endcase
            expect_ctrl = r;
        end
    endfunction

    // called at the accepting edge, flags already updated
    task automatic model_accept(input logic [31:0] w);
        dec_t        rec;
        logic        pass;
        logic [31:0] ofs;
        begin
            pass          = cond_holds(w[31:28], model_flags);
            rec.pc        = model_pc;
            rec.rd        = (w[27:25] == 3'b101 && w[24]) ? `ARM_REG_W'(`ARM_LINK_REG) : w[15:12];
            rec.ctrl      = pass ? expect_ctrl(w) : '0;
            rec.cond_pass = pass;
            ofs = {{(`ARM_WORD_W - `ARM_BOFS_W){w[`ARM_BOFS_W-1]}}, w[`ARM_BOFS_W-1:0]};
            // target counts from the branch pc plus 4
            if (w[27:25] == 3'b101 && pass)
                model_pc = model_pc + `ARM_PC_STEP + (ofs << 2);
            else
                model_pc = model_pc + `ARM_PC_STEP;
            exp_q.push_back(rec);
            acc_cyc_q.push_back(cycle_count);
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        begin
            assert (got === exp)
            else
            begin
                value_errors++;
                $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
            end
        end
    endtask

    // starts and ends on a falling edge
    task automatic send_instr(input logic [31:0] word);
        begin
            instr_valid = 1'b1;
            instr       = word;
            while (!instr_ready)
                @(negedge clk);
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    task automatic set_flags(input logic [3:0] value);
        begin
            // only load NZCV into an empty pipeline
            while (exp_q.size() != 0)
                @(negedge clk);
            flags_we = 1'b1;
            flags    = value;
            @(negedge clk);
            flags_we = 1'b0;
        end
    endtask

    always @(posedge clk)
    begin
        if (rst_n)
        begin
            // two in flight means both slices are full
            if (exp_q.size() == 2)
                check_value("instr_ready", instr_ready, dec_ready);
            if (fixed_lat)
                check_value("instr_ready", instr_ready, 1'b1);
            if (!instr_ready)
                ready_low_seen = 1'b1;
            if (hold_valid)
            begin
                check_value("dec_valid", dec_valid, 1'b1);
                check_value("held record", {dec_pc, dec_rd, dec_ctrl, dec_cond_pass}, hold_rec);
            end
            if (flags_we)
                model_flags = flags;
            if (dec_valid && dec_ready)
            begin
                assert (exp_q.size() != 0)
                else
                begin
                    other_errors++;
                    $display("%0t ns: record delivered with no instruction outstanding", $time);
                end
                if (exp_q.size() != 0)
                begin
                    exp_rec = exp_q.pop_front();
                    acc_cyc = acc_cyc_q.pop_front();
                    check_value("dec_pc", dec_pc, exp_rec.pc);
                    check_value("dec_rd", dec_rd, exp_rec.rd);
                    check_value("dec_ctrl", dec_ctrl, exp_rec.ctrl);
                    check_value("dec_cond_pass", dec_cond_pass, exp_rec.cond_pass);
                    if (records_seen == 0)
                        check_value("first dec_pc", dec_pc, 0);
                    if (fixed_lat)
                        check_value("latency", cycle_count - acc_cyc, 2);
                    records_seen++;
                end
            end
            if (instr_valid && instr_ready)
                model_accept(instr);
            hold_valid = dec_valid && !dec_ready;
            hold_rec   = {dec_pc, dec_rd, dec_ctrl, dec_cond_pass};
        end
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the pipeline stopped moving", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial
    begin
        int          i;
        int          t;
        int          issued;
        logic        took;
        logic [31:0] w;
        logic [31:0] br [6];

        seed = 47570;
        clk = 1'b0;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        flags_we = 1'b0;
        flags = '0;
        dec_ready = 1'b1;
        value_errors = 0;
        other_errors = 0;
        cycle_count = 0;
        records_seen = 0;
        fixed_lat = 1'b1;
        ready_low_seen = 1'b0;
        model_pc = '0;
        model_flags = '0;
        hold_valid = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("dec_valid", dec_valid, 1'b0);
        check_value("instr_ready", instr_ready, 1'b1);

        // every class value under AL, back to back
        for (i = 0; i < N_CLASS; i++)
        begin
            w = $random(seed);
            w[31:28] = COND_AL;
            w[27:25] = 3'(i);
            send_instr(w);
        end

        // all sixteen codes per random flag value
        for (t = 0; t < N_TRIALS; t++)
        begin
            set_flags($random(seed));
            for (i = 0; i < 16; i++)
            begin
                w = $random(seed);
                w[31:28] = 4'(i);
                send_instr(w);
            end
        end

        // Z set: EQ passes, NE fails
        set_flags(4'b0100);
        br[0] = {COND_AL, 3'b101, 1'b0, 24'd5};
        br[1] = {COND_AL, 3'b101, 1'b0, 24'hfffffd};
        br[2] = {COND_EQ, 3'b101, 1'b0, 24'd100};
        br[3] = {COND_NE, 3'b101, 1'b0, 24'd7};
        br[4] = {COND_AL, 3'b101, 1'b1, 24'hffffc0};
        br[5] = {COND_AL, 3'b101, 1'b1, 24'h800000};
        for (i = 0; i < 6; i++)
        begin
            send_instr(br[i]);
            send_instr({COND_AL, 3'b001, 25'h0a1b2c3});
        end

        // random traffic with back-pressure
        set_flags($random(seed));
        fixed_lat = 1'b0;
        issued = 0;
        while (issued < N_RAND)
        begin
            dec_ready = $random(seed);
            if (!instr_valid && ($random(seed) & 3) != 0)
            begin
                instr_valid = 1'b1;
                instr = $random(seed);
            end
            #1;
            took = instr_valid && instr_ready;
            @(negedge clk);
            if (took)
            begin
                instr_valid = 1'b0;
                issued++;
            end
        end
        dec_ready = 1'b1;
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (2) @(negedge clk);

        assert (ready_low_seen)
        else
        begin
            other_errors++;
            $display("instr_ready never dropped while both slices were full");
        end
        check_value("records", records_seen, N_TOTAL);
        $display("run done: %0d records, %0d value errors, %0d other errors",
                 records_seen, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
arm_dec_pkg.sv
stage_reg.sv
insn_decoder.sv
cond_unit.sv
pc_unit.sv
arm_fetch_decode.sv
tb_arm_fetch_decode.sv

// File: Bender.yml
package:
  name: arm_fetch_decode

export_include_dirs:
  - .

sources:
  - arm_dec_pkg.sv
  - stage_reg.sv
  - insn_decoder.sv
  - cond_unit.sv
  - pc_unit.sv
  - arm_fetch_decode.sv
  - target: test
    files:
      - tb_arm_fetch_decode.sv
